//--- Bender.yml
package:
  name: versat_agen

export_include_dirs:
  - src

sources:
  - files:
      - src/versatPkg.sv
      - src/addrGen.sv
      - src/addrGen4Loop.sv
      - src/agenConfig.sv
      - src/memBanks.sv
      - src/versatTop.sv
  - target: test
    files:
      - tests/versatTb.sv

//--- build.f
+incdir+src
src/versatPkg.sv
src/addrGen.sv
src/addrGen4Loop.sv
src/agenConfig.sv
src/memBanks.sv
src/versatTop.sv
tests/versatTb.sv

//--- src/addrGen.sv
`timescale 1ns/1ps

module addrGen (
   input  logic              clk,
   input  logic              rst,
   input  logic              init,
   input  logic              run,
   input  logic              pause,
   input  versatPkg::addrT   iterations,
   input  versatPkg::periodT period,
   input  versatPkg::periodT duty,
   input  versatPkg::periodT delay,
   input  versatPkg::addrT   start,
   input  versatPkg::offsetT shift,
   input  versatPkg::offsetT incr,
   output versatPkg::addrT   addr,
   output logic              memEn,
   output logic              done
);

   versatPkg::agenStateT state;
   versatPkg::addrT      addrReg;
   versatPkg::periodT    dlyCnt;
   versatPkg::periodT    perCnt;
   versatPkg::addrT      iterCnt;
   logic                 active;
   logic                 lastCol;
   logic                 lastIter;

   assign active = (state == versatPkg::RUN) || (state == versatPkg::PAUSE);

   // a period of zero behaves like a period of one
   assign lastCol  = ({1'b0, perCnt} + 1'b1) >= {1'b0, period};
   assign lastIter = ({1'b0, iterCnt} + 1'b1) >= {1'b0, iterations};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= versatPkg::IDLE;
         addrReg <= '0;
         dlyCnt  <= '0;
         perCnt  <= '0;
         iterCnt <= '0;
      end else if (init || run) begin
         if (init) begin
            addrReg <= start;
            perCnt  <= '0;
            iterCnt <= '0;
         end
         if (run) begin
            dlyCnt <= delay;
            if (iterations == '0) begin
               state <= versatPkg::DONE;
            end else if (delay == '0) begin
               state <= versatPkg::RUN;
            end else begin
               state <= versatPkg::DELAY;
            end
         end else begin
            state <= versatPkg::IDLE;
         end
      end else begin
         case (state)
            versatPkg::DELAY: begin
               if (!pause) begin
                  if (dlyCnt == versatPkg::periodT'(1)) begin
                     state <= versatPkg::RUN;
                  end else begin
                     dlyCnt <= dlyCnt - 1'b1;
                  end
               end
            end
            versatPkg::RUN, versatPkg::PAUSE: begin
               if (pause) begin
                  state <= versatPkg::PAUSE;
               end else if (lastCol) begin
                  // end of a pass: shift replaces the increment
                  perCnt  <= '0;
                  addrReg <= addrReg + versatPkg::addrT'(shift);
                  iterCnt <= iterCnt + 1'b1;
                  state   <= lastIter ? versatPkg::DONE : versatPkg::RUN;
               end else begin
                  perCnt  <= perCnt + 1'b1;
                  addrReg <= addrReg + versatPkg::addrT'(incr);
                  state   <= versatPkg::RUN;
               end
            end
            default: begin
               state <= state;
            end
         endcase
      end
   end

   assign addr = addrReg;

   // enable covers the first duty cycles of every period
   assign memEn = active && (perCnt < duty);

   // idle generators count as finished
   assign done = (state == versatPkg::IDLE) || (state == versatPkg::DONE);

   // the chaining logic never starts a generator it is holding
   assert property (@(posedge clk) disable iff (rst) run |-> !pause)
      else $error("addrGen started while paused");

endmodule

//--- src/addrGen4Loop.sv
`timescale 1ns/1ps

module addrGen4Loop (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  versatPkg::addrT   iterations,
   input  versatPkg::periodT period,
   input  versatPkg::periodT duty,
   input  versatPkg::periodT delay,
   input  versatPkg::addrT   start,
   input  versatPkg::offsetT shift,
   input  versatPkg::offsetT incr,
   input  versatPkg::addrT   iterations2,
   input  versatPkg::periodT period2,
   input  versatPkg::offsetT shift2,
   input  versatPkg::offsetT incr2,
   output versatPkg::addrT   addr,
   output logic              memEn,
   output logic              done
);

   versatPkg::addrT   addrOuter;
   versatPkg::addrT   startInner;
   versatPkg::periodT delayInner;
   logic              memEnOuter;
   logic              doneOuter;
   logic              doneInner;
   logic              doneInnerReg;
   logic              readyInner;
   logic              readyOuter;
   logic              firstStep;
   logic              restartInner;
   logic              runInner;
   logic              pauseOuter;

   assign readyInner = |iterations;
   assign readyOuter = |iterations2;

   // inner pattern just ended while the outer still holds an address
   assign restartInner = doneInner & ~doneInnerReg & memEnOuter;
   assign runInner     = run | restartInner;

   // first pattern starts at start, later ones at the outer address
   assign startInner = run ? start : addrOuter;
   assign delayInner = run ? delay : '0;

   // outer steps right after its own start and on each inner restart,
   // so it always has the next start address ready
   assign pauseOuter = ~(run | firstStep | restartInner);

   assign done = doneInner & (doneOuter | ~readyOuter) & ~run;

   addrGen u_inner (
      .clk        (clk),
      .rst        (rst),
      .init       (runInner),
      .run        (runInner & readyInner),
      .pause      (1'b0),
      .iterations (iterations),
      .period     (period),
      .duty       (duty),
      .delay      (delayInner),
      .start      (startInner),
      .shift      (shift),
      .incr       (incr),
      .addr       (addr),
      .memEn      (memEn),
      .done       (doneInner)
   );

   // outer level walks the pattern starts, enabled on every cycle
   addrGen u_outer (
      .clk        (clk),
      .rst        (rst),
      .init       (run),
      .run        (run & readyOuter & readyInner),
      .pause      (pauseOuter),
      .iterations (iterations2),
      .period     (period2),
      .duty       (period2),
      .delay      ('0),
      .start      (start),
      .shift      (shift2),
      .incr       (incr2),
      .addr       (addrOuter),
      .memEn      (memEnOuter),
      .done       (doneOuter)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         doneInnerReg <= 1'b1;
         firstStep    <= 1'b0;
      end else begin
         doneInnerReg <= doneInner;
         firstStep    <= run & readyOuter;
      end
   end

   // a finished port stays finished until the next run starts it
   assert property (@(posedge clk) disable iff (rst) done |=> done || run)
      else $error("port left done without a run");

endmodule

//--- src/agenConfig.sv
`timescale 1ns/1ps
`include "versat_macros.svh"

module agenConfig (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfgWe,
   input  versatPkg::portIdT   cfgPort,
   input  versatPkg::cfgFieldT cfgField,
   input  versatPkg::addrT     cfgData,
   input  logic                run,
   input  logic                allDone,
   output versatPkg::addrT     iterations  [`NUM_PORTS],
   output versatPkg::periodT   period      [`NUM_PORTS],
   output versatPkg::periodT   duty        [`NUM_PORTS],
   output versatPkg::periodT   delay       [`NUM_PORTS],
   output versatPkg::addrT     start       [`NUM_PORTS],
   output versatPkg::offsetT   shift       [`NUM_PORTS],
   output versatPkg::offsetT   incr        [`NUM_PORTS],
   output versatPkg::addrT     iterations2 [`NUM_PORTS],
   output versatPkg::periodT   period2     [`NUM_PORTS],
   output versatPkg::offsetT   shift2      [`NUM_PORTS],
   output versatPkg::offsetT   incr2       [`NUM_PORTS],
   output logic                portRun,
   output logic                busy
);

   logic              cfgAccept;
   versatPkg::periodT cfgShort;

   assign cfgAccept = cfgWe & ~busy;
   assign cfgShort  = cfgData[`PERIOD_W-1:0];
   assign portRun   = run & ~busy;

   // ports left unprogrammed keep zero iterations and stay disabled
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int p = 0; p < `NUM_PORTS; p++) begin
            iterations[p]  <= '0;
            period[p]      <= '0;
            duty[p]        <= '0;
            delay[p]       <= '0;
            start[p]       <= '0;
            shift[p]       <= '0;
            incr[p]        <= '0;
            iterations2[p] <= '0;
            period2[p]     <= '0;
            shift2[p]      <= '0;
            incr2[p]       <= '0;
         end
      end else if (cfgAccept) begin
         case (cfgField)
            versatPkg::fieldIterations:  iterations[cfgPort]  <= cfgData;
            versatPkg::fieldPeriod:      period[cfgPort]      <= cfgShort;
            versatPkg::fieldDuty:        duty[cfgPort]        <= cfgShort;
            versatPkg::fieldDelay:       delay[cfgPort]       <= cfgShort;
            versatPkg::fieldStart:       start[cfgPort]       <= cfgData;
            versatPkg::fieldShift:       shift[cfgPort]       <= versatPkg::offsetT'(cfgData);
            versatPkg::fieldIncr:        incr[cfgPort]        <= versatPkg::offsetT'(cfgData);
            versatPkg::fieldIterations2: iterations2[cfgPort] <= cfgData;
            versatPkg::fieldPeriod2:     period2[cfgPort]     <= cfgShort;
            versatPkg::fieldShift2:      shift2[cfgPort]      <= versatPkg::offsetT'(cfgData);
            versatPkg::fieldIncr2:       incr2[cfgPort]       <= versatPkg::offsetT'(cfgData);
            default: begin
            end
         endcase
      end
   end

   // busy from an accepted run until every port has finished
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (portRun) begin
         busy <= 1'b1;
      end else if (allDone) begin
         busy <= 1'b0;
      end
   end

   // every port drops done during an accepted run, so busy cannot clear at once
   assert property (@(posedge clk) disable iff (rst) portRun |=> !allDone)
      else $error("allDone still high after an accepted run");

endmodule

//--- src/memBanks.sv
`timescale 1ns/1ps
`include "versat_macros.svh"

module memBanks (
   input  logic              clk,
   input  logic              rst,
   input  versatPkg::addrT   addr    [`NUM_PORTS],
   input  logic              memEn   [`NUM_PORTS],
   input  logic              genDone [`NUM_PORTS],
   input  logic              memWe,
   input  versatPkg::portIdT memPort,
   input  versatPkg::addrT   memAddr,
   input  versatPkg::dataT   memData,
   output versatPkg::dataT   rdData  [`NUM_PORTS],
   output logic              rdValid [`NUM_PORTS],
   output logic              allDone
);

   localparam int ramDepth = 1 << `MEM_ADDR_W;

   logic [`NUM_PORTS-1:0] doneVec;

   for (genvar p = 0; p < `NUM_PORTS; p++) begin : gBank
      versatPkg::dataT ram [ramDepth];
      versatPkg::dataT rdReg;
      logic            validReg;
      logic            wrHit;

      assign wrHit = memWe && (memPort == versatPkg::portIdT'(p));

      // preload write and generated read share one clock
      always_ff @(posedge clk) begin
         if (wrHit) begin
            ram[memAddr] <= memData;
         end
         if (memEn[p]) begin
            rdReg <= ram[addr[p]];
         end
      end

      always_ff @(posedge clk or posedge rst) begin
         if (rst) begin
            validReg <= 1'b0;
         end else begin
            validReg <= memEn[p];
         end
      end

      assign rdData[p]  = rdReg;
      assign rdValid[p] = validReg;
      assign doneVec[p] = genDone[p];

      // preload must not overlap the generator reading this bank
      assert property (@(posedge clk) disable iff (rst) !(wrHit && memEn[p]))
         else $error("preload write collides with read on port %0d", p);
   end

   // idle ports count as done, so this is high out of reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         allDone <= 1'b1;
      end else begin
         allDone <= &doneVec;
      end
   end

endmodule

//--- src/versatPkg.sv
`include "versat_macros.svh"

package versatPkg;

   typedef logic [`MEM_ADDR_W-1:0]        addrT;
   typedef logic signed [`MEM_ADDR_W-1:0] offsetT;
   typedef logic [`PERIOD_W-1:0]          periodT;
   typedef logic [`DATA_W-1:0]            dataT;
   typedef logic [$clog2(`NUM_PORTS)-1:0] portIdT;
   typedef logic [`CFG_FIELD_W-1:0]       cfgFieldT;

   typedef enum logic [2:0] {IDLE, DELAY, RUN, PAUSE, DONE} agenStateT;

   // field codes for cfgField
   localparam cfgFieldT fieldIterations  = cfgFieldT'(0);
   localparam cfgFieldT fieldPeriod      = cfgFieldT'(1);
   localparam cfgFieldT fieldDuty        = cfgFieldT'(2);
   localparam cfgFieldT fieldDelay       = cfgFieldT'(3);
   localparam cfgFieldT fieldStart       = cfgFieldT'(4);
   localparam cfgFieldT fieldShift       = cfgFieldT'(5);
   localparam cfgFieldT fieldIncr        = cfgFieldT'(6);
   localparam cfgFieldT fieldIterations2 = cfgFieldT'(7);
   localparam cfgFieldT fieldPeriod2     = cfgFieldT'(8);
   localparam cfgFieldT fieldShift2      = cfgFieldT'(9);
   localparam cfgFieldT fieldIncr2       = cfgFieldT'(10);

endpackage

//--- src/versatTop.sv
`timescale 1ns/1ps
`include "versat_macros.svh"

module versatTop (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfgWe,
   input  versatPkg::portIdT   cfgPort,
   input  versatPkg::cfgFieldT cfgField,
   input  versatPkg::addrT     cfgData,
   input  logic                memWe,
   input  versatPkg::portIdT   memPort,
   input  versatPkg::addrT     memAddr,
   input  versatPkg::dataT     memData,
   input  logic                run,
   output versatPkg::dataT     rdData  [`NUM_PORTS],
   output logic                rdValid [`NUM_PORTS],
   output logic                allDone,
   output logic                busy
);

   versatPkg::addrT   iterations  [`NUM_PORTS];
   versatPkg::periodT period      [`NUM_PORTS];
   versatPkg::periodT duty        [`NUM_PORTS];
   versatPkg::periodT delay       [`NUM_PORTS];
   versatPkg::addrT   start       [`NUM_PORTS];
   versatPkg::offsetT shift       [`NUM_PORTS];
   versatPkg::offsetT incr        [`NUM_PORTS];
   versatPkg::addrT   iterations2 [`NUM_PORTS];
   versatPkg::periodT period2     [`NUM_PORTS];
   versatPkg::offsetT shift2      [`NUM_PORTS];
   versatPkg::offsetT incr2       [`NUM_PORTS];
   versatPkg::addrT   genAddr     [`NUM_PORTS];
   logic              genMemEn    [`NUM_PORTS];
   logic              genDone     [`NUM_PORTS];
   logic              portRun;

   agenConfig u_config (
      .clk, .rst, .cfgWe, .cfgPort, .cfgField, .cfgData, .run, .allDone,
      .iterations, .period, .duty, .delay, .start, .shift, .incr,
      .iterations2, .period2, .shift2, .incr2,
      .portRun, .busy
   );

   // one four-loop generator per port, all started together
   for (genvar p = 0; p < `NUM_PORTS; p++) begin : gAgen
      addrGen4Loop u_agen (
         .clk         (clk),
         .rst         (rst),
         .run         (portRun),
         .iterations  (iterations[p]),
         .period      (period[p]),
         .duty        (duty[p]),
         .delay       (delay[p]),
         .start       (start[p]),
         .shift       (shift[p]),
         .incr        (incr[p]),
         .iterations2 (iterations2[p]),
         .period2     (period2[p]),
         .shift2      (shift2[p]),
         .incr2       (incr2[p]),
         .addr        (genAddr[p]),
         .memEn       (genMemEn[p]),
         .done        (genDone[p])
      );
   end

   memBanks u_banks (
      .clk     (clk),
      .rst     (rst),
      .addr    (genAddr),
      .memEn   (genMemEn),
      .genDone (genDone),
      .memWe   (memWe),
      .memPort (memPort),
      .memAddr (memAddr),
      .memData (memData),
      .rdData  (rdData),
      .rdValid (rdValid),
      .allDone (allDone)
   );

endmodule

//--- src/versat_macros.svh
`ifndef VERSAT_MACROS_SVH
`define VERSAT_MACROS_SVH

// memory address width, also the width of all configuration data
`define MEM_ADDR_W 10

// period, duty and delay counters
`define PERIOD_W 5

// ram word width
`define DATA_W 16

// one address generator and one bank per port
`define NUM_PORTS 4

// configuration field selector
`define CFG_FIELD_W 4

`endif

//--- tests/agen_stim.txt
# P port addr data (addr and data in hex) overwrites one filled RAM word
# T name starts a test, then one C line per port with the fields in this order
# iterations period duty delay start shift incr iterations2 period2 shift2 incr2
# R name reruns the last configuration while field writes are issued during busy
P 0 010 beef
P 0 011 1234
P 1 064 cafe
P 2 3e8 0bad
P 2 006 f00d
P 3 005 a5a5
P 3 3ff 5a5a
# single loop with duty equal to period
T contig
C 4 4 4 0 16 1 1 0 0 0 0
C 8 1 1 0 100 1 0 0 0 0 0
C 0 0 0 0 0 0 0 0 0 0 0
C 2 3 3 2 500 1 2 0 0 0 0
# duty below period with delays and address wrap
T gapped
C 3 5 2 4 40 -2 3 0 0 0 0
C 4 4 1 1 200 0 5 0 0 0 0
C 2 6 3 7 1000 10 4 0 0 0 0
C 0 0 0 0 0 0 0 0 0 0 0
# four loops with negative outer steps
T nested
C 2 2 2 0 300 1 1 3 1 -10 0
C 1 3 3 0 700 0 -1 2 2 -20 -5
C 2 4 2 3 50 2 1 2 1 8 0
C 1 1 1 0 5 0 0 4 1 -3 0
# all ports busy with different lengths
T mixed
C 5 3 2 2 900 -7 3 2 2 40 -9
C 16 1 1 0 0 3 0 0 0 0 0
C 3 2 1 6 128 4 2 3 1 -64 0
C 2 5 5 1 1020 0 1 2 1 6 0
# ports with zero iterations finish at once
T idlePort
C 0 4 4 0 64 1 1 2 1 4 0
C 6 4 3 0 160 2 -1 2 1 -30 0
C 0 0 0 0 0 0 0 0 0 0 0
C 4 3 3 5 400 0 2 0 0 0 0
R busyWrite

//--- tests/versatTb.sv
`timescale 1ns/1ps
`include "versat_macros.svh"

module versatTb;

   localparam int numFields = 11;
   localparam int maxTests  = 16;
   localparam int maxReads  = 1024;
   localparam int ramDepth  = 1 << `MEM_ADDR_W;

   logic                clk;
   logic                rst;
   logic                cfgWe;
   versatPkg::portIdT   cfgPort;
   versatPkg::cfgFieldT cfgField;
   versatPkg::addrT     cfgData;
   logic                memWe;
   versatPkg::portIdT   memPort;
   versatPkg::addrT     memAddr;
   versatPkg::dataT     memData;
   logic                run;
   versatPkg::dataT     rdData  [`NUM_PORTS];
   logic                rdValid [`NUM_PORTS];
   logic                allDone;
   logic                busy;

   // software copy of the banks and the decoded stimulus
   versatPkg::dataT     mirror    [`NUM_PORTS][ramDepth];
   versatPkg::cfgFieldT fieldCode [numFields];
   int                  cfgTab    [maxTests][`NUM_PORTS][numFields];
   string               testName  [maxTests];
   bit                  rerun     [maxTests];
   int                  expAddr   [`NUM_PORTS][maxReads];
   int                  expLen    [`NUM_PORTS];
   int                  numTests;
   int                  streamLen;
   int                  doneAt;
   bit                  timedOut;
   int                  errors;
   int                  testsPassed;
   int                  testsFailed;

   versatTop u_versatTop (
      .clk, .rst, .cfgWe, .cfgPort, .cfgField, .cfgData,
      .memWe, .memPort, .memAddr, .memData, .run,
      .rdData, .rdValid, .allDone, .busy
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int wrapAddr(input int a);
      return ((a % ramDepth) + ramDepth) % ramDepth;
   endfunction

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         errors++;
         $display("[FAIL] %0t %s got %0h expected %0h", $time, what, got, expected);
      end
   endtask

   task automatic fillMirror();
      logic [31:0] lcg;
      lcg = 32'h93bd_5d08;
      for (int p = 0; p < `NUM_PORTS; p++) begin
         for (int a = 0; a < ramDepth; a++) begin
            lcg = lcgNext(lcg);
            mirror[p][a] = lcg[31:16];
         end
      end
   endtask

   task automatic readStim();
      int    fd;
      int    code;
      int    ch;
      int    t;
      int    p;
      int    port;
      int    addr;
      int    data;
      string tag;
      numTests = 0;
      fd = $fopen("tests/agen_stim.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open the stimulus file tests/agen_stim.txt");
      end else begin
         t = 0;
         p = 0;
         while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
               ch = $fgetc(fd);
               while (ch != 10 && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else if (tag == "P") begin
               code = $fscanf(fd, "%d %h %h", port, addr, data);
               if (code != 3) begin
                  errors++;
                  $display("malformed preload line in the stimulus file");
               end else begin
                  mirror[port][addr] = versatPkg::dataT'(data);
               end
            end else if (tag == "T" || tag == "R") begin
               t = numTests;
               numTests++;
               p = 0;
               code = $fscanf(fd, "%s", testName[t]);
               rerun[t] = (tag == "R");
               // a rerun keeps whatever was programmed last
               if (rerun[t] && t > 0) begin
                  cfgTab[t] = cfgTab[t-1];
               end
            end else if (tag == "C") begin
               for (int f = 0; f < numFields; f++) begin
                  code = $fscanf(fd, "%d", cfgTab[t][p][f]);
                  if (code != 1) begin
                     errors++;
                     $display("short configuration line for test %s", testName[t]);
                  end
               end
               p++;
            end else begin
               errors++;
               $display("unknown line tag %s in the stimulus file", tag);
            end
         end
         $fclose(fd);
      end
   endtask

   // address list of one port from the inner and outer loop rules
   task automatic expandPort(input int t, input int p);
      int iter;
      int per;
      int duty;
      int inc;
      int step;
      int per2;
      int step2;
      int nOuter;
      int base;
      int portEnd;
      iter   = cfgTab[t][p][0];
      per    = (cfgTab[t][p][1] == 0) ? 1 : cfgTab[t][p][1];
      duty   = cfgTab[t][p][2];
      inc    = cfgTab[t][p][6];
      step   = (per - 1) * inc + cfgTab[t][p][5];
      per2   = (cfgTab[t][p][8] == 0) ? 1 : cfgTab[t][p][8];
      step2  = (per2 - 1) * cfgTab[t][p][10] + cfgTab[t][p][9];
      nOuter = (cfgTab[t][p][7] == 0 || cfgTab[t][p][8] == 0) ? 1 : cfgTab[t][p][7] * per2;
      if (iter == 0) begin
         nOuter = 0;
      end
      // done rises after the delay, every pattern and one restart cycle per pattern
      portEnd = (nOuter == 0) ? 1 : cfgTab[t][p][3] + nOuter * (iter * per + 1);
      if (portEnd + 1 > doneAt) begin
         doneAt = portEnd + 1;
      end
      expLen[p] = 0;
      streamLen += cfgTab[t][p][3];
      for (int k = 0; k < nOuter; k++) begin
         // outer address k is the start of inner pattern k
         base = cfgTab[t][p][4] + (k / per2) * step2 + (k % per2) * cfgTab[t][p][10];
         streamLen += iter * per + 1;
         for (int i = 0; i < iter; i++) begin
            for (int j = 0; j < per && j < duty; j++) begin
               if (expLen[p] < maxReads) begin
                  expAddr[p][expLen[p]] = wrapAddr(base + i * step + j * inc);
               end
               expLen[p]++;
            end
         end
      end
   endtask

   task automatic runTest(input int t);
      int cnt [`NUM_PORTS];
      int limit;
      int cycle;
      int doneCycle;
      int junk;
      int errBefore;
      errBefore = errors;
      streamLen = 0;
      doneAt    = 0;
      for (int p = 0; p < `NUM_PORTS; p++) begin
         expandPort(t, p);
         cnt[p] = 0;
      end
      limit = 4 * streamLen + 200;
      if (!rerun[t]) begin
         for (int p = 0; p < `NUM_PORTS; p++) begin
            for (int f = 0; f < numFields; f++) begin
               @(negedge clk);
               cfgWe    = 1'b1;
               cfgPort  = versatPkg::portIdT'(p);
               cfgField = fieldCode[f];
               cfgData  = versatPkg::addrT'(cfgTab[t][p][f]);
            end
         end
      end
      @(negedge clk);
      cfgWe = 1'b0;
      run   = 1'b1;
      @(negedge clk);
      run       = 1'b0;
      cycle     = 1;
      doneCycle = 0;
      junk      = 0;
      while (busy && !timedOut) begin
         for (int p = 0; p < `NUM_PORTS; p++) begin
            if (rdValid[p] === 1'b1) begin
               if (cnt[p] < expLen[p]) begin
                  checkValue($sformatf("%s port %0d read %0d at %0h", testName[t], p, cnt[p],
                                       expAddr[p][cnt[p]]),
                             rdData[p], mirror[p][expAddr[p][cnt[p]]]);
               end else begin
                  errors++;
                  $display("test %s port %0d returned more reads than its pattern holds",
                           testName[t], p);
               end
               cnt[p]++;
            end
         end
         if (allDone && doneCycle == 0) begin
            doneCycle = cycle;
            for (int p = 0; p < `NUM_PORTS; p++) begin
               checkValue($sformatf("%s port %0d reads at allDone", testName[t], p),
                          cnt[p], expLen[p]);
            end
         end
         // a rerun writes every field while the ports are busy
         if (rerun[t] && junk < numFields) begin
            cfgWe    = 1'b1;
            cfgPort  = versatPkg::portIdT'(junk);
            cfgField = fieldCode[junk];
            cfgData  = '1;
            junk++;
         end else begin
            cfgWe = 1'b0;
         end
         if (cycle >= limit) begin
            errors++;
            timedOut = 1'b1;
            $display("test %s timed out after %0d cycles with busy still high",
                     testName[t], cycle);
         end else begin
            @(negedge clk);
            cycle++;
         end
      end
      cfgWe = 1'b0;
      if (!timedOut && doneCycle == 0) begin
         errors++;
         $display("test %s saw busy fall without allDone going high", testName[t]);
      end else if (doneCycle != 0) begin
         checkValue($sformatf("%s allDone cycle", testName[t]), doneCycle, doneAt);
      end
      if (errors == errBefore) begin
         testsPassed++;
         $display("test %s ok after %0d cycles", testName[t], cycle);
      end else begin
         testsFailed++;
         $display("test %s failed with %0d errors", testName[t], errors - errBefore);
      end
   endtask

   initial begin
      rst         = 1'b1;
      cfgWe       = 1'b0;
      cfgPort     = '0;
      cfgField    = '0;
      cfgData     = '0;
      memWe       = 1'b0;
      memPort     = '0;
      memAddr     = '0;
      memData     = '0;
      run         = 1'b0;
      errors      = 0;
      testsPassed = 0;
      testsFailed = 0;
      timedOut    = 1'b0;
      fieldCode = '{versatPkg::fieldIterations, versatPkg::fieldPeriod, versatPkg::fieldDuty,
                    versatPkg::fieldDelay, versatPkg::fieldStart, versatPkg::fieldShift,
                    versatPkg::fieldIncr, versatPkg::fieldIterations2, versatPkg::fieldPeriod2,
                    versatPkg::fieldShift2, versatPkg::fieldIncr2};
      fillMirror();
      readStim();
      repeat (3) @(negedge clk);
      rst = 1'b0;
      // idle generators report done and nothing is reading
      checkValue("busy after reset", busy, 0);
      checkValue("allDone after reset", allDone, 1);
      for (int p = 0; p < `NUM_PORTS; p++) begin
         checkValue($sformatf("port %0d rdValid after reset", p), rdValid[p], 0);
      end
      // copy the mirror into the banks through the preload port
      for (int p = 0; p < `NUM_PORTS; p++) begin
         for (int a = 0; a < ramDepth; a++) begin
            @(negedge clk);
            memWe   = 1'b1;
            memPort = versatPkg::portIdT'(p);
            memAddr = versatPkg::addrT'(a);
            memData = mirror[p][a];
         end
      end
      @(negedge clk);
      memWe = 1'b0;
      for (int t = 0; t < numTests && !timedOut; t++) begin
         runTest(t);
      end
      $display("tests %0d, passed %0d, failed %0d, failing checks %0d",
               numTests, testsPassed, testsFailed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
